// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
TOP       ?= tb_rp_acq
FLIST     ?= rp_acq_top.f
PASS_MSG  := No errors

.PHONY: simulate clean

# build, run, then look for the pass line in the captured output
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: rp_acq_top.f
+incdir+test
verilog/rp_adc_pkg.sv
verilog/rp_hk_pkg.sv
verilog/rp_idly_if.sv
verilog/rp_adc_lane.sv
verilog/rp_hk_regs.sv
verilog/rp_acq_top.sv
test/tb_rp_acq.sv

// File: test/tb_rp_acq_tasks.svh
`ifndef TB_RP_ACQ_TASKS_SVH
`define TB_RP_ACQ_TASKS_SVH

//////////////////////////////////////////////////
// run control and compares
//////////////////////////////////////////////////

task automatic abort_run();
  $display("Errors found");
  $fatal(1, "stopped at first failure");
endtask

task automatic cmp_data(input string name, input rp_hk_pkg::apb_data_t exp,
                        input rp_hk_pkg::apb_data_t act);
  if (act !== exp)
  begin
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic cmp_err(input string name, input logic exp, input logic act);
  if (act !== exp)
  begin
    $display("FAILED %s: expected pslverr %b, actual %b", name, exp, act);
    abort_run();
  end
endtask

task automatic cmp_led(input string name, input rp_hk_pkg::led_t exp,
                       input rp_hk_pkg::led_t act);
  if (act !== exp)
  begin
    $display("FAILED %s: expected led %h, actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic cmp_exp(input string name, input logic [EXP_W-1:0] exp,
                       input logic [EXP_W-1:0] act);
  if (act !== exp)
  begin
    $display("FAILED %s: expected pins %h, actual %h", name, exp, act);
    abort_run();
  end
endtask

//////////////////////////////////////////////////
// stimulus helpers
//////////////////////////////////////////////////

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        b;
  r = '0;
  for (int i = 0; i < n; i++)
  begin
    b      = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b)
      lfsr_q = lfsr_q ^ 32'h8020_0003;  // taps 32 22 2 1
    r[i] = b;
  end
  return r;
endfunction

// even bits go with the rising edge, odd with the falling
function automatic rp_adc_pkg::adc_lines_t ddr_half(input rp_adc_pkg::adc_word_t w,
                                                     input logic odd);
  rp_adc_pkg::adc_lines_t h;
  for (int j = 0; j < rp_adc_pkg::ADC_LINES; j++)
    h[j] = w[2 * j + int'(odd)];
  return h;
endfunction

task automatic next_cycle();
  @(posedge clk_i);
  #1;  // inputs move just after the edge
endtask

// zero wait APB transfer, sampled mid access phase
task automatic apb_xfer(input logic wr, input rp_hk_pkg::apb_addr_t addr,
                        input rp_hk_pkg::apb_data_t wdat,
                        output rp_hk_pkg::apb_data_t rdat, output logic err);
  psel_i   = 1'b1;  // setup phase
  pwrite_i = wr;
  paddr_i  = addr;
  pwdata_i = wdat;
  @(negedge clk_i);
  if (pready_o)
  begin
    $display("pready_o was already high in the setup phase to address %h", addr);
    abort_run();
  end
  next_cycle();
  penable_i = 1'b1;
  @(negedge clk_i);
  if (!pready_o)
  begin
    $display("pready_o stayed low in the access phase to address %h", addr);
    abort_run();
  end
  rdat = prdata_o;
  err  = pslverr_o;
  next_cycle();  // write lands on this edge
  psel_i    = 1'b0;
  penable_i = 1'b0;
  pwrite_i  = 1'b0;
endtask

`endif

// File: test/tb_rp_acq.sv
`timescale 1ns/1ns

module tb_rp_acq;

  localparam int                   EXP_W   = 9;
  localparam rp_hk_pkg::apb_data_t HK_ID   = 32'h5250_0a01;  // off default on purpose
  localparam int                   TAP_N   = rp_adc_pkg::ADC_CH * rp_adc_pkg::ADC_LINES;
  localparam int                   OP_WR   = 0;  // APB write
  localparam int                   OP_RD   = 1;  // APB read
  localparam int                   OP_ADC  = 2;  // hold a sample pattern
  localparam int                   OP_GPIO = 3;  // drive expansion pins

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  rp_hk_pkg::apb_addr_t   paddr_i;
  rp_hk_pkg::apb_data_t   pwdata_i;
  rp_hk_pkg::apb_data_t   prdata_o;
  logic                   pready_o;
  logic                   pslverr_o;
  rp_adc_pkg::adc_lines_t adc0_dat_i;
  rp_adc_pkg::adc_lines_t adc1_dat_i;
  logic [EXP_W-1:0]       exp_dat_i;
  logic [EXP_W-1:0]       exp_dat_o;
  logic [EXP_W-1:0]       exp_dir_o;
  rp_hk_pkg::led_t        led_o;

  rp_adc_pkg::adc_word_t  smp0;             // pattern on channel 0
  rp_adc_pkg::adc_word_t  smp1;             // pattern on channel 1
  rp_adc_pkg::tap_cnt_t   tap_mdl [TAP_N];  // expected tap per line
  logic [31:0]            lfsr_q = 32'h6f40_71f5;
  logic                   table_ready = 1'b0;

  // stimulus table, row r spread over the queues
  string                  name_q [$];
  int                     op_q   [$];
  rp_hk_pkg::apb_addr_t   addr_q [$];
  rp_hk_pkg::apb_data_t   data_q [$];
  rp_hk_pkg::apb_data_t   exp_q  [$];
  logic                   err_q  [$];

  `include "tb_rp_acq_tasks.svh"

  rp_acq_top #(
    .EXP_W (EXP_W),
    .HK_ID (HK_ID)
  ) dut0 (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;  // 10 ns period
  end

  //////////////////////////////////////////////////
  // table building
  //////////////////////////////////////////////////

  task automatic add_row(input string name, input int op, input rp_hk_pkg::apb_addr_t addr,
                         input rp_hk_pkg::apb_data_t data, input rp_hk_pkg::apb_data_t exp,
                         input logic err);
    name_q.push_back(name);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    exp_q.push_back(exp);
    err_q.push_back(err);
  endtask

  function automatic rp_hk_pkg::apb_addr_t tap_addr(input int n);
    return rp_hk_pkg::apb_addr_t'(rp_hk_pkg::REG_TAP_BASE + 4 * n);
  endfunction

  // delay control write, model stepped alongside
  task automatic idly_cmd(input string tag, input rp_hk_pkg::apb_data_t mask,
                          input logic ld, input logic ce, input logic inc);
    rp_hk_pkg::apb_data_t w;
    w                          = '0;
    w[TAP_N-1:0]               = mask[TAP_N-1:0];
    w[rp_hk_pkg::IDLY_INC_BIT] = inc;
    w[rp_hk_pkg::IDLY_CE_BIT]  = ce;
    w[rp_hk_pkg::IDLY_LD_BIT]  = ld;
    add_row(tag, OP_WR, rp_hk_pkg::REG_IDLY_CTRL, w, '0, 1'b0);
    for (int n = 0; n < TAP_N; n++)
    begin
      if (mask[n] && ld)
        tap_mdl[n] = '0;  // load beats step
      else if (mask[n] && ce && inc)
        tap_mdl[n] = tap_mdl[n] + 5'd1;
      else if (mask[n] && ce)
        tap_mdl[n] = tap_mdl[n] - 5'd1;
    end
  endtask

  task automatic tap_reads(input string tag);
    for (int n = 0; n < TAP_N; n++)
      add_row($sformatf("%s tap%0d", tag, n), OP_RD, tap_addr(n), '0,
              rp_hk_pkg::apb_data_t'(tap_mdl[n]), 1'b0);
  endtask

  task automatic build_table();
    rp_hk_pkg::apb_data_t v;
    rp_hk_pkg::apb_data_t s0;
    rp_hk_pkg::apb_data_t s1;
    foreach (tap_mdl[n])
      tap_mdl[n] = '0;
    tap_reads("reset");
    add_row("adc0 reset", OP_RD, rp_hk_pkg::REG_ADC0, '0, '0, 1'b0);
    add_row("id", OP_RD, rp_hk_pkg::REG_ID, '0, HK_ID, 1'b0);
    v = rand_bits(8);
    add_row("led write", OP_WR, rp_hk_pkg::REG_LED, v, v, 1'b0);
    add_row("led read", OP_RD, rp_hk_pkg::REG_LED, '0, v, 1'b0);
    v = rand_bits(EXP_W);
    add_row("dir write", OP_WR, rp_hk_pkg::REG_EXP_DIR, v, v, 1'b0);
    add_row("dir read", OP_RD, rp_hk_pkg::REG_EXP_DIR, '0, v, 1'b0);
    v = rand_bits(EXP_W);
    add_row("out write", OP_WR, rp_hk_pkg::REG_EXP_OUT, v, v, 1'b0);
    add_row("out read", OP_RD, rp_hk_pkg::REG_EXP_OUT, '0, v, 1'b0);
    v = rand_bits(EXP_W);
    add_row("pins in", OP_GPIO, '0, v, '0, 1'b0);
    add_row("pins read", OP_RD, rp_hk_pkg::REG_EXP_IN, '0, v, 1'b0);
    s0 = rand_bits(rp_adc_pkg::ADC_DW);
    s1 = rand_bits(rp_adc_pkg::ADC_DW);
    add_row("adc pattern", OP_ADC, '0, s0 | (s1 << 16), '0, 1'b0);  // ch1 in [29:16]
    add_row("adc0 read", OP_RD, rp_hk_pkg::REG_ADC0, '0, s0, 1'b0);
    add_row("adc1 read", OP_RD, rp_hk_pkg::REG_ADC1, '0, s1, 1'b0);
    // tap counters
    idly_cmd("ld all", 32'h3fff, 1'b1, 1'b0, 1'b0);
    tap_reads("ld");
    idly_cmd("inc subset", rand_bits(TAP_N), 1'b0, 1'b1, 1'b1);
    idly_cmd("inc subset", rand_bits(TAP_N), 1'b0, 1'b1, 1'b1);
    tap_reads("inc");
    idly_cmd("ld with ce", 32'h3fff, 1'b1, 1'b1, 1'b1);
    tap_reads("ld over ce");
    idly_cmd("dec subset", rand_bits(TAP_N), 1'b0, 1'b1, 1'b0);
    tap_reads("dec");  // masked lines at 31
    idly_cmd("ld all", 32'h3fff, 1'b1, 1'b0, 1'b0);
    for (int i = 0; i < 32; i++)
    begin
      idly_cmd("inc line9", 32'h0200, 1'b0, 1'b1, 1'b1);
      add_row($sformatf("wrap step%0d", i), OP_RD, tap_addr(9), '0,
              rp_hk_pkg::apb_data_t'(tap_mdl[9]), 1'b0);
    end
    // error responses
    add_row("unmapped read", OP_RD, 12'h0fc, '0, '0, 1'b1);
    add_row("tap past end", OP_RD, tap_addr(TAP_N), '0, '0, 1'b1);
    add_row("adc0 write", OP_WR, rp_hk_pkg::REG_ADC0, ~s0, '0, 1'b1);
    add_row("adc0 kept", OP_RD, rp_hk_pkg::REG_ADC0, '0, s0, 1'b0);
    add_row("ctrl read", OP_RD, rp_hk_pkg::REG_IDLY_CTRL, '0, '0, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // DDR pins and watchdog
  //////////////////////////////////////////////////

  // pattern picked up at the edge, pins move 1 ns later
  initial
  begin
    rp_adc_pkg::adc_lines_t h0;
    rp_adc_pkg::adc_lines_t h1;
    adc0_dat_i = '0;
    adc1_dat_i = '0;
    forever
    begin
      @(negedge clk_i);
      h0 = ddr_half(smp0, 1'b0);  // sampled at next rising edge
      h1 = ddr_half(smp1, 1'b0);
      #1;
      adc0_dat_i = h0;
      adc1_dat_i = h1;
      @(posedge clk_i);
      h0 = ddr_half(smp0, 1'b1);  // sampled at next falling edge
      h1 = ddr_half(smp1, 1'b1);
      #1;
      adc0_dat_i = h0;
      adc1_dat_i = h1;
    end
  end

  initial
  begin
    wait (table_ready);
    #((name_q.size() * 20 + 16) * 10);  // 20 cycles a row plus reset
    $display("timeout, the stimulus table did not finish in time");
    abort_run();
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    rp_hk_pkg::apb_data_t rdat;
    logic                 rerr;
    rst_n_i   = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    exp_dat_i = '0;
    smp0      = '0;
    smp1      = '0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    cmp_led("led after reset", '0, led_o);
    cmp_exp("dir after reset", '0, exp_dir_o);  // all pins input
    cmp_exp("out after reset", '0, exp_dat_o);
    foreach (name_q[r])
    begin
      case (op_q[r])
        OP_WR:
        begin
          apb_xfer(1'b1, addr_q[r], data_q[r], rdat, rerr);
          cmp_err(name_q[r], err_q[r], rerr);
          if (addr_q[r] == rp_hk_pkg::REG_LED)
            cmp_led(name_q[r], rp_hk_pkg::led_t'(exp_q[r]), led_o);
          else if (addr_q[r] == rp_hk_pkg::REG_EXP_DIR)
            cmp_exp(name_q[r], exp_q[r][EXP_W-1:0], exp_dir_o);
          else if (addr_q[r] == rp_hk_pkg::REG_EXP_OUT)
            cmp_exp(name_q[r], exp_q[r][EXP_W-1:0], exp_dat_o);
        end
        OP_RD:
        begin
          apb_xfer(1'b0, addr_q[r], '0, rdat, rerr);
          cmp_err(name_q[r], err_q[r], rerr);
          cmp_data(name_q[r], exp_q[r], rdat);
        end
        OP_ADC:
        begin
          smp0 = data_q[r][13:0];
          smp1 = data_q[r][29:16];
          repeat (4) next_cycle();  // capture plus sample register
        end
        default:
        begin
          exp_dat_i = data_q[r][EXP_W-1:0];
          repeat (3) next_cycle();  // two sync flops and margin
        end
      endcase
    end
    $display("No errors");
    $finish;
  end

endmodule: tb_rp_acq

// File: verilog/rp_acq_top.sv
`timescale 1ns/1ns

module rp_acq_top #(
  parameter int                   EXP_W = 9,             // expansion bank width
  parameter rp_hk_pkg::apb_data_t HK_ID = 32'h0000_0001  // board identification
)(
  // system
  input  logic                   clk_i,       // ADC clock drives everything
  input  logic                   rst_n_i,
  // APB
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  rp_hk_pkg::apb_addr_t   paddr_i,
  input  rp_hk_pkg::apb_data_t   pwdata_i,
  output rp_hk_pkg::apb_data_t   prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // ADC
  input  rp_adc_pkg::adc_lines_t adc0_dat_i,  // channel 0 DDR lines
  input  rp_adc_pkg::adc_lines_t adc1_dat_i,  // channel 1 DDR lines
  // expansion connector
  input  logic [EXP_W-1:0]       exp_dat_i,
  output logic [EXP_W-1:0]       exp_dat_o,
  output logic [EXP_W-1:0]       exp_dir_o,   // 1 = output enable
  // LED
  output rp_hk_pkg::led_t        led_o
);

  //////////////////////////////////////////////////
  // per channel delay and sample links
  //////////////////////////////////////////////////

  rp_idly_if lane0_if ();  // channel 0
  rp_idly_if lane1_if ();  // channel 1

  //////////////////////////////////////////////////
  // ADC capture lanes
  //////////////////////////////////////////////////

  // channel 0
  rp_adc_lane lane0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .adc_dat_i (adc0_dat_i),
    .idly      (lane0_if.lane)
  );

  // channel 1, same timing as ch0
  rp_adc_lane lane1 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .adc_dat_i (adc1_dat_i),
    .idly      (lane1_if.lane)
  );

  //////////////////////////////////////////////////
  // housekeeping
  //////////////////////////////////////////////////

  // register file joins both lanes on the bus
  rp_hk_regs #(
    .EXP_W (EXP_W),
    .HK_ID (HK_ID)
  ) hk0 (
    // system
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    // APB
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    // LED
    .led_o     (led_o),
    // GPIO, no tristate here
    .exp_dat_i (exp_dat_i),
    .exp_dat_o (exp_dat_o),
    .exp_dir_o (exp_dir_o),
    // delay control
    .lane0     (lane0_if.ctrl),
    .lane1     (lane1_if.ctrl)
  );

endmodule: rp_acq_top

// File: verilog/rp_adc_lane.sv
`timescale 1ns/1ns

module rp_adc_lane (
  input  logic                   clk_i,      // ADC clock, also system clock
  input  logic                   rst_n_i,
  input  rp_adc_pkg::adc_lines_t adc_dat_i,  // DDR pins after input delay
  rp_idly_if.lane                idly        // control in, taps and sample out
);

  rp_adc_pkg::adc_lines_t rise_q;  // rising edge half
  rp_adc_pkg::adc_lines_t fall_q;  // falling edge half
  rp_adc_pkg::adc_word_t  smp_d;   // interleaved halves
  rp_adc_pkg::adc_word_t  smp_q;
  rp_adc_pkg::tap_vec_t   tap_q;

  //////////////////////////////////////////////////
  // DDR capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rise_q <= '0;
    else
      rise_q <= adc_dat_i;  // Q1 stage
  end

  // fall half held until the next rising edge
  always_ff @(negedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      fall_q <= '0;
    else
      fall_q <= adc_dat_i;
  end

  // bit 2j from rise, 2j+1 from fall
  always_comb
  begin
    for (int j = 0; j < rp_adc_pkg::ADC_LINES; j++)
    begin
      smp_d[2*j]   = rise_q[j];
      smp_d[2*j+1] = fall_q[j];  // odd position
    end
  end

  // both halves registered on one edge, same-edge pipelined
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      smp_q <= '0;  // sample reads zero out of reset
    else
      smp_q <= smp_d;
  end

  assign idly.adc_dat = smp_q;

  //////////////////////////////////////////////////
  // tap counters
  //////////////////////////////////////////////////

  // one per line, wrap both ways
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      tap_q <= '0;
    else
    begin
      for (int n = 0; n < rp_adc_pkg::ADC_LINES; n++)
      begin
        if (idly.idly_ld[n])
          tap_q[n] <= '0;  // ld wins over ce
        else if (idly.idly_ce[n])
        begin
          if (idly.idly_inc[n])
            tap_q[n] <= tap_q[n] + rp_adc_pkg::tap_cnt_t'(1);  // 31 -> 0
          else
            tap_q[n] <= tap_q[n] - rp_adc_pkg::tap_cnt_t'(1);  // 0 -> 31
        end
      end
    end
  end

  assign idly.idly_cnt = tap_q;

endmodule: rp_adc_lane

// File: verilog/rp_adc_pkg.sv
//////////////////////////////////////////////////
// ADC input path definitions
//////////////////////////////////////////////////

package rp_adc_pkg;

  // DDR lines per channel, two bits per line per clock
  localparam int ADC_LINES = 7;
  localparam int ADC_DW    = 14;  // one full sample
  localparam int TAP_W     = 5;   // idelay tap range 0..31
  localparam int ADC_CH    = 2;   // scope channels

  // raw pin vector of one channel
  typedef logic [ADC_LINES-1:0] adc_lines_t;

  // assembled sample, rise bits even, fall bits odd
  typedef logic [ADC_DW-1:0] adc_word_t;

  // single tap counter
  typedef logic [TAP_W-1:0] tap_cnt_t;

  // all tap counters of one channel
  typedef tap_cnt_t [ADC_LINES-1:0] tap_vec_t;

endpackage: rp_adc_pkg

// File: verilog/rp_hk_pkg.sv
//////////////////////////////////////////////////
// housekeeping bus and register map
//////////////////////////////////////////////////

package rp_hk_pkg;

  localparam int APB_AW = 12;  // 4 KB window
  localparam int APB_DW = 32;

  typedef logic [APB_AW-1:0] apb_addr_t;
  typedef logic [APB_DW-1:0] apb_data_t;
  typedef logic [8-1:0]      led_t;  // eight board LEDs

  //////////////////////////////////////////////////
  // register offsets
  //////////////////////////////////////////////////

  localparam apb_addr_t REG_ID        = 12'h000;  // ro
  localparam apb_addr_t REG_LED       = 12'h004;  // rw
  localparam apb_addr_t REG_EXP_DIR   = 12'h010;  // rw, 1 = output
  localparam apb_addr_t REG_EXP_OUT   = 12'h014;  // rw
  localparam apb_addr_t REG_EXP_IN    = 12'h018;  // ro, synchronized pins
  localparam apb_addr_t REG_IDLY_CTRL = 12'h020;  // wo, pulse generator
  localparam apb_addr_t REG_ADC0      = 12'h028;  // ro
  localparam apb_addr_t REG_ADC1      = 12'h02C;  // ro
  // tap counts, one word per line, ch0 first then ch1
  localparam apb_addr_t REG_TAP_BASE  = 12'h040;

  // IDLY_CTRL fields
  localparam int IDLY_MASK_LSB = 0;   // line mask, 14 bits
  localparam int IDLY_INC_BIT  = 16;  // direction
  localparam int IDLY_CE_BIT   = 17;  // step enable
  localparam int IDLY_LD_BIT   = 18;  // reload to zero

endpackage: rp_hk_pkg

// File: verilog/rp_hk_regs.sv
`timescale 1ns/1ns

module rp_hk_regs #(
  parameter int                   EXP_W = 9,             // expansion bank width
  parameter rp_hk_pkg::apb_data_t HK_ID = 32'h0000_0001  // returned at REG_ID
)(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // APB slave, zero wait
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  rp_hk_pkg::apb_addr_t paddr_i,
  input  rp_hk_pkg::apb_data_t pwdata_i,
  output rp_hk_pkg::apb_data_t prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  // LED
  output rp_hk_pkg::led_t      led_o,
  // expansion GPIO
  input  logic [EXP_W-1:0]     exp_dat_i,  // async pins
  output logic [EXP_W-1:0]     exp_dat_o,
  output logic [EXP_W-1:0]     exp_dir_o,  // 1 = drive
  // capture lanes
  rp_idly_if.ctrl              lane0,
  rp_idly_if.ctrl              lane1
);

  // lines over both channels
  localparam int TAP_N  = rp_adc_pkg::ADC_CH * rp_adc_pkg::ADC_LINES;
  localparam int TAP_IW = $clog2(TAP_N);
  localparam rp_hk_pkg::apb_addr_t TAP_END =
    rp_hk_pkg::REG_TAP_BASE + rp_hk_pkg::apb_addr_t'(4 * TAP_N);

  logic                             apb_acc;   // access phase
  logic                             rd_ok;     // address readable
  logic                             wr_ok;     // address writable
  logic                             acc_err;
  logic                             wr_en;
  rp_hk_pkg::apb_data_t             rd_dat;
  rp_hk_pkg::apb_addr_t             tap_off;
  logic [TAP_IW-1:0]                tap_idx;
  logic                             tap_hit;
  rp_adc_pkg::tap_cnt_t [TAP_N-1:0] tap_all;   // ch1 lines on top
  rp_hk_pkg::led_t                  led_q;
  logic [EXP_W-1:0]                 dir_q;
  logic [EXP_W-1:0]                 out_q;
  logic [EXP_W-1:0]                 sync0_q;   // metastability stage
  logic [EXP_W-1:0]                 sync1_q;
  logic [TAP_N-1:0]                 idly_msk;
  logic [TAP_N-1:0]                 ld_q;
  logic [TAP_N-1:0]                 ce_q;
  logic [TAP_N-1:0]                 inc_q;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign tap_all = {lane1.idly_cnt, lane0.idly_cnt};
  assign tap_off = paddr_i - rp_hk_pkg::REG_TAP_BASE;
  assign tap_idx = tap_off[TAP_IW+1:2];  // word index = line number
  assign tap_hit = (paddr_i >= rp_hk_pkg::REG_TAP_BASE) && (paddr_i < TAP_END)
                   && (paddr_i[1:0] == 2'b00);

  always_comb
  begin
    rd_dat = '0;
    rd_ok  = 1'b0;
    wr_ok  = 1'b0;
    case (paddr_i)
      rp_hk_pkg::REG_ID:
      begin
        rd_ok  = 1'b1;
        rd_dat = HK_ID;
      end
      rp_hk_pkg::REG_LED:
      begin
        rd_ok  = 1'b1;
        wr_ok  = 1'b1;
        rd_dat = rp_hk_pkg::apb_data_t'(led_q);
      end
      rp_hk_pkg::REG_EXP_DIR:
      begin
        rd_ok  = 1'b1;
        wr_ok  = 1'b1;
        rd_dat = rp_hk_pkg::apb_data_t'(dir_q);
      end
      rp_hk_pkg::REG_EXP_OUT:
      begin
        rd_ok  = 1'b1;
        wr_ok  = 1'b1;
        rd_dat = rp_hk_pkg::apb_data_t'(out_q);
      end
      rp_hk_pkg::REG_EXP_IN:
      begin
        rd_ok  = 1'b1;
        rd_dat = rp_hk_pkg::apb_data_t'(sync1_q);
      end
      rp_hk_pkg::REG_IDLY_CTRL:
        wr_ok  = 1'b1;  // pulses only, nothing to read back
      rp_hk_pkg::REG_ADC0:
      begin
        rd_ok  = 1'b1;
        rd_dat = rp_hk_pkg::apb_data_t'(lane0.adc_dat);
      end
      rp_hk_pkg::REG_ADC1:
      begin
        rd_ok  = 1'b1;
        rd_dat = rp_hk_pkg::apb_data_t'(lane1.adc_dat);
      end
      default:
      begin
        if (tap_hit)  // tap readback window
        begin
          rd_ok  = 1'b1;
          rd_dat = rp_hk_pkg::apb_data_t'(tap_all[tap_idx]);
        end
      end
    endcase
  end

  // zero wait, answer in the same access phase
  assign apb_acc   = psel_i & penable_i;
  assign acc_err   = pwrite_i ? !wr_ok : !rd_ok;
  assign wr_en     = apb_acc & pwrite_i & wr_ok;  // bad writes dropped here
  assign pready_o  = apb_acc;
  assign pslverr_o = apb_acc & acc_err;
  assign prdata_o  = (apb_acc && !pwrite_i && rd_ok) ? rd_dat : '0;

  //////////////////////////////////////////////////
  // LED and GPIO registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      led_q <= '0;
      dir_q <= '0;  // all pins input
      out_q <= '0;
    end
    else if (wr_en)
    begin
      case (paddr_i)
        rp_hk_pkg::REG_LED:     led_q <= rp_hk_pkg::led_t'(pwdata_i);
        rp_hk_pkg::REG_EXP_DIR: dir_q <= pwdata_i[EXP_W-1:0];
        rp_hk_pkg::REG_EXP_OUT: out_q <= pwdata_i[EXP_W-1:0];
        default: ;
      endcase
    end
  end

  // two flop synchronizer on the pins
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sync0_q <= '0;
      sync1_q <= '0;
    end
    else
    begin
      sync0_q <= exp_dat_i;
      sync1_q <= sync0_q;
    end
  end

  assign led_o     = led_q;
  assign exp_dir_o = dir_q;
  assign exp_dat_o = out_q;

  //////////////////////////////////////////////////
  // delay control pulses
  //////////////////////////////////////////////////

  assign idly_msk = pwdata_i[rp_hk_pkg::IDLY_MASK_LSB +: TAP_N];

  // single cycle after the write, then back to idle
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ld_q  <= '0;
      ce_q  <= '0;
      inc_q <= '0;
    end
    else if (wr_en && (paddr_i == rp_hk_pkg::REG_IDLY_CTRL))
    begin
      ld_q  <= idly_msk & {TAP_N{pwdata_i[rp_hk_pkg::IDLY_LD_BIT]}};
      ce_q  <= idly_msk & {TAP_N{pwdata_i[rp_hk_pkg::IDLY_CE_BIT]}};
      inc_q <= idly_msk & {TAP_N{pwdata_i[rp_hk_pkg::IDLY_INC_BIT]}};
    end
    else
    begin
      ld_q  <= '0;
      ce_q  <= '0;
      inc_q <= '0;
    end
  end

  // mask split, low lines to ch0
  assign lane0.idly_ld  = ld_q[rp_adc_pkg::ADC_LINES-1:0];
  assign lane0.idly_ce  = ce_q[rp_adc_pkg::ADC_LINES-1:0];
  assign lane0.idly_inc = inc_q[rp_adc_pkg::ADC_LINES-1:0];
  assign lane1.idly_ld  = ld_q[TAP_N-1:rp_adc_pkg::ADC_LINES];
  assign lane1.idly_ce  = ce_q[TAP_N-1:rp_adc_pkg::ADC_LINES];
  assign lane1.idly_inc = inc_q[TAP_N-1:rp_adc_pkg::ADC_LINES];

endmodule: rp_hk_regs

// File: verilog/rp_idly_if.sv
`timescale 1ns/1ns

//////////////////////////////////////////////////
// delay control and sample path of one channel
//////////////////////////////////////////////////

interface rp_idly_if;

  // control pulses, one bit per DDR line
  rp_adc_pkg::adc_lines_t idly_ld;   // load tap to zero
  rp_adc_pkg::adc_lines_t idly_ce;   // step enable
  rp_adc_pkg::adc_lines_t idly_inc;  // step up when set, down otherwise

  // status coming back from the lane
  rp_adc_pkg::tap_vec_t   idly_cnt;  // current tap per line
  rp_adc_pkg::adc_word_t  adc_dat;   // latest sample

  // housekeeping side
  modport ctrl (
    output idly_ld,
    output idly_ce,
    output idly_inc,
    input  idly_cnt,
    input  adc_dat
  );

  // capture lane side
  modport lane (
    input  idly_ld,
    input  idly_ce,
    input  idly_inc,
    output idly_cnt,
    output adc_dat
  );

endinterface: rp_idly_if
